/* Makefile */
VERILATOR := verilator
VFLAGS    := --binary --timing -j 0
LINTFLAGS := --lint-only --timing -Wall
TOP       := tb_mem_1r1u
FILELIST  := tb.f
OBJ_DIR   := obj_dir
LOG       := sim.log

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: build
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@grep -qx "TB PASSED" $(LOG)

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* bench/mem_1r1u_stim.txt */
// Columns: read rd_adr write din check expected_dout, hex, one line per clock cycle
// A "test <name>" line starts a test; check and expected_dout belong to the read on that line
test reset_idle
0 00 0 0000 0 0000
0 00 0 0000 0 0000
0 00 0 0000 0 0000
test rmw_plain
1 03 0 0000 0 0000
1 14 0 0000 0 0000
1 25 1 aaaa 0 0000
1 36 1 bbbb 0 0000
0 00 1 cccc 0 0000
0 00 1 dddd 0 0000
1 03 0 0000 1 aaaa
1 14 0 0000 1 bbbb
1 25 0 0000 1 cccc
1 36 0 0000 1 dddd
0 00 0 0000 0 0000
0 00 0 0000 0 0000
test bank_conflict
1 07 0 0000 0 0000
0 00 0 0000 0 0000
1 03 1 1111 1 aaaa
0 00 0 0000 0 0000
1 07 1 2222 1 1111
0 00 0 0000 0 0000
1 03 0 0000 1 2222
0 00 0 0000 0 0000
0 00 0 0000 0 0000
test spare_evict
1 13 0 0000 0 0000
0 00 0 0000 0 0000
1 14 1 3333 1 bbbb
0 00 0 0000 0 0000
1 03 0 0000 1 2222
1 13 0 0000 1 3333
1 07 1 4444 1 1111
1 13 0 0000 1 3333
1 03 0 0000 1 4444
0 00 0 0000 0 0000
0 00 0 0000 0 0000
test back_to_back
1 25 0 0000 1 cccc
1 25 0 0000 1 cccc
1 25 1 5001 1 cccc
1 25 1 5002 1 5001
1 25 1 5003 1 5002
1 25 1 5004 1 5003
0 00 1 5005 0 0000
1 25 1 5006 1 5005
1 25 0 0000 1 5006
0 00 0 0000 0 0000
0 00 0 0000 0 0000
test mixed_traffic
1 36 0 0000 1 dddd
1 15 0 0000 0 0000
1 35 1 6001 0 0000
1 05 1 6002 0 0000
1 13 1 6003 1 3333
1 03 1 6004 1 4444
1 25 1 6005 1 5006
1 05 1 6006 1 6004
1 35 1 6007 1 6003
1 36 1 6008 1 6001
1 03 1 6009 1 6006
1 25 0 0000 1 6007
1 05 0 0000 1 6008
1 35 0 0000 1 6009
1 15 0 0000 1 6002
0 00 0 0000 0 0000
0 00 0 0000 0 0000

/* bench/tb_mem_1r1u.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_mem_1r1u;

  localparam int reset_cycles = 10;
  localparam int drain_margin = 50;

  typedef struct packed {
    int                              cyc;
    logic [mem_cfg_pkg::bitaddr-1:0] adr;
    logic                            chk;
    logic [mem_cfg_pkg::width-1:0]   exp_file;
    logic                            known;
    logic [mem_cfg_pkg::width-1:0]   exp_model;
  } rd_entry_t;

  logic                            clk;
  logic                            rst;
  logic                            read;
  logic [mem_cfg_pkg::bitaddr-1:0] rd_adr;
  logic                            write;
  logic [mem_cfg_pkg::width-1:0]   din;
  logic                            rd_vld;
  logic [mem_cfg_pkg::width-1:0]   rd_dout;

  logic [mem_cfg_pkg::width-1:0] ref_mem [int];  // Latest update per address
  rd_entry_t                     pend [$];       // Reads still waiting for rd_vld
  string                         lines [$];
  int                            cyc;
  int                            cycle_cnt;
  int                            cycle_limit;
  int                            err_cnt;
  int                            check_cnt;
  int                            tests;
  int                            tests_failed;

  mem_1r1u_top i_dut (
    .clk     (clk),
    .rst     (rst),
    .read    (read),
    .rd_adr  (rd_adr),
    .write   (write),
    .din     (din),
    .rd_vld  (rd_vld),
    .rd_dout (rd_dout)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  initial begin
    cycle_cnt = 0;
    wait (cycle_limit > 0);
    while (cycle_cnt < cycle_limit) begin
      @(posedge clk);
      cycle_cnt++;
    end
    $display("Timeout: the run did not finish within %0d cycles", cycle_limit);
    $display("TB FAILED");
    $finish;
  end

  task automatic load_stim(output int n_cycles);
    int    fd;
    string line;
    n_cycles = 0;
    fd = $fopen("bench/mem_1r1u_stim.txt", "r");
    if (fd == 0) begin
      $display("Could not open the stimulus file bench/mem_1r1u_stim.txt");
      err_cnt++;
    end else begin
      while ($fgets(line, fd) != 0) begin
        if (line.len() > 2 && line.substr(0, 1) != "//") begin
          lines.push_back(line);
          if (line.substr(0, 3) != "test") begin
            n_cycles++;
          end
        end
      end
      $fclose(fd);
    end
  endtask

  task automatic report_test(input string name, input int errs);
    tests++;
    if (errs == 0) begin
      $display("Test %s: ok", name);
    end else begin
      tests_failed++;
      $display("Test %s: %0d errors", name, errs);
    end
  endtask

  // The read issued sram_delay cycles ago must show up now, and only then
  task automatic check_response();
    rd_entry_t head;
    if (pend.size() > 0 && pend[0].cyc == cyc - mem_cfg_pkg::sram_delay) begin
      head = pend.pop_front();
      check_cnt++;
      if (rd_vld !== 1'b1) begin
        $display("[FAIL] cycle %0d rd_vld: got %h, expected 1", cyc, rd_vld);
        err_cnt++;
      end
      if (head.chk && rd_dout !== head.exp_file) begin
        $display("[FAIL] cycle %0d rd_dout adr %h: got %h, file expects %h",
                 cyc, head.adr, rd_dout, head.exp_file);
        err_cnt++;
      end
      if (head.known && rd_dout !== head.exp_model) begin
        $display("[FAIL] cycle %0d rd_dout adr %h: got %h, model expects %h",
                 cyc, head.adr, rd_dout, head.exp_model);
        err_cnt++;
      end
    end else if (rd_vld !== 1'b0) begin
      $display("[FAIL] cycle %0d rd_vld: got %h, expected 0", cyc, rd_vld);
      err_cnt++;
    end
  endtask

  task automatic run_cycle(input string line);
    int        n;
    int        rd_i;
    int        adr_i;
    int        wr_i;
    int        din_i;
    int        chk_i;
    int        exp_i;
    rd_entry_t ent;
    n = $sscanf(line, "%h %h %h %h %h %h", rd_i, adr_i, wr_i, din_i, chk_i, exp_i);
    @(posedge clk);
    #1;
    cyc++;
    if (n != 6) begin
      $display("Stimulus line for cycle %0d is malformed, driven as idle", cyc);
      err_cnt++;
      rd_i = 0;
      wr_i = 0;
    end
    read   = rd_i[0];
    rd_adr = adr_i[mem_cfg_pkg::bitaddr-1:0];
    write  = wr_i[0];
    din    = din_i[mem_cfg_pkg::width-1:0];
    ent.cyc      = cyc;
    ent.adr      = rd_adr;
    ent.chk      = chk_i[0];
    ent.exp_file = exp_i[mem_cfg_pkg::width-1:0];
    ent.known    = (ref_mem.exists(int'(rd_adr)) != 0);
    if (ent.known) begin
      ent.exp_model = ref_mem[int'(rd_adr)];  // Snapshot before this cycle's update
    end else begin
      ent.exp_model = '0;
    end
    if (write) begin
      if (pend.size() > 0 && pend[0].cyc == cyc - mem_cfg_pkg::sram_delay) begin
        ref_mem[int'(pend[0].adr)] = din;
      end else begin
        $display("Cycle %0d: write strobe without a read %0d cycles earlier",
                 cyc, mem_cfg_pkg::sram_delay);
        err_cnt++;
      end
    end
    @(negedge clk);
    check_response();
    if (read) begin
      pend.push_back(ent);
    end
  endtask

  initial begin
    string cur_test;
    string name;
    string line;
    int    test_base;
    int    n_cycles;
    rst          = 1'b1;
    read         = 1'b0;
    rd_adr       = '0;
    write        = 1'b0;
    din          = '0;
    cyc          = 0;
    err_cnt      = 0;
    check_cnt    = 0;
    tests        = 0;
    tests_failed = 0;
    cur_test     = "";
    test_base    = 0;
    load_stim(n_cycles);
    cycle_limit = reset_cycles + n_cycles + drain_margin;
    repeat (reset_cycles) @(posedge clk);
    #1;
    rst = 1'b0;
    foreach (lines[i]) begin
      line = lines[i];
      if (line.substr(0, 3) == "test") begin
        if (cur_test != "") begin
          report_test(cur_test, err_cnt - test_base);
        end
        void'($sscanf(line, "test %s", name));
        cur_test  = name;
        test_base = err_cnt;
      end else begin
        run_cycle(line);
      end
    end
    if (pend.size() != 0) begin
      $display("%0d reads never got a response before the stimulus ended", pend.size());
      err_cnt++;
    end
    if (cur_test != "") begin
      report_test(cur_test, err_cnt - test_base);
    end
    $display("Summary: %0d tests, %0d failed, %0d reads checked, %0d errors",
             tests, tests_failed, check_cnt, err_cnt);
    if (err_cnt == 0) begin
      $display("TB PASSED");
    end else begin
      $display("TB FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* src/mem_1r1u_top.sv */
`timescale 1ns/1ps
`default_nettype none

module mem_1r1u_top (
  input  logic                            clk,
  input  logic                            rst,
  input  logic                            read,
  input  logic [mem_cfg_pkg::bitaddr-1:0] rd_adr,
  input  logic                            write,
  input  logic [mem_cfg_pkg::width-1:0]   din,
  output logic                            rd_vld,
  output logic [mem_cfg_pkg::width-1:0]   rd_dout
);

  mem_types_pkg::bank_req_t      bank_req [mem_cfg_pkg::numvbnk];
  logic [mem_cfg_pkg::width-1:0] bank_dout [mem_cfg_pkg::numvbnk];
  mem_types_pkg::dp_req_t        spare_req;
  logic [mem_cfg_pkg::width-1:0] spare_dout;
  mem_types_pkg::map_req_t       map_req;
  mem_types_pkg::map_entry_t     map_dout;

  rmw_ctrl i_ctrl (
    .clk        (clk),
    .rst        (rst),
    .read       (read),
    .rd_adr     (rd_adr),
    .write      (write),
    .din        (din),
    .bank_req   (bank_req),
    .spare_req  (spare_req),
    .map_req    (map_req),
    .bank_dout  (bank_dout),
    .spare_dout (spare_dout),
    .map_dout   (map_dout),
    .rd_vld     (rd_vld),
    .rd_dout    (rd_dout)
  );

  generate
    for (genvar i = 0; i < mem_cfg_pkg::numvbnk; i++) begin : g_t1
      sram_1p #(
        .width (mem_cfg_pkg::width),
        .depth (mem_cfg_pkg::numvrow)
      ) i_bank (
        .clk  (clk),
        .req  (bank_req[i]),
        .dout (bank_dout[i])
      );
    end
  endgenerate

  sram_1r1w #(
    .width (mem_cfg_pkg::width),
    .depth (mem_cfg_pkg::numvrow)
  ) spare_mem (
    .clk     (clk),
    .wr_en   (spare_req.write),
    .wr_row  (spare_req.wr_row),
    .wr_din  (spare_req.din),
    .rd_en   (spare_req.read),
    .rd_row  (spare_req.rd_row),
    .rd_dout (spare_dout)
  );

  sram_1r1w #(
    .width (mem_cfg_pkg::map_width),
    .depth (mem_cfg_pkg::numvrow)
  ) map_mem (
    .clk     (clk),
    .wr_en   (map_req.write),
    .wr_row  (map_req.wr_row),
    .wr_din  (map_req.din),
    .rd_en   (map_req.read),
    .rd_row  (map_req.rd_row),
    .rd_dout (map_dout)
  );

endmodule

`default_nettype wire

/* src/mem_cfg_pkg.sv */
`default_nettype none

package mem_cfg_pkg;

  // Data word stored per address
  localparam int width = 16;

  // Single-port data banks (t1)
  localparam int numvbnk = 4;
  localparam int bitvbnk = 2;

  // Rows per bank, also the depth of t2 and t3
  localparam int numvrow = 16;
  localparam int bitvrow = 4;

  // Logical address is {bank, row}
  localparam int bitaddr = bitvbnk + bitvrow;

  // Read latency of every memory in the design
  localparam int sram_delay = 2;

  // One map word is a valid bit plus a bank index
  localparam int map_width = bitvbnk + 1;

endpackage

`default_nettype wire

/* src/mem_types_pkg.sv */
`default_nettype none

package mem_types_pkg;

  typedef struct packed {
    logic                             vld;   // t2 holds this row's word
    logic [mem_cfg_pkg::bitvbnk-1:0]  bank;  // Bank the t2 word belongs to
  } map_entry_t;

  typedef struct packed {
    logic                             read;
    logic                             write;
    logic [mem_cfg_pkg::bitvrow-1:0]  row;
    logic [mem_cfg_pkg::width-1:0]    din;
  } bank_req_t;

  typedef struct packed {
    logic                             write;
    logic [mem_cfg_pkg::bitvrow-1:0]  wr_row;
    logic [mem_cfg_pkg::width-1:0]    din;
    logic                             read;
    logic [mem_cfg_pkg::bitvrow-1:0]  rd_row;
  } dp_req_t;

  typedef struct packed {
    logic                             write;
    logic [mem_cfg_pkg::bitvrow-1:0]  wr_row;
    map_entry_t                       din;
    logic                             read;
    logic [mem_cfg_pkg::bitvrow-1:0]  rd_row;
  } map_req_t;

  typedef enum logic [1:0] {
    upd_none,
    upd_bank,
    upd_spare,
    upd_spare_evict
  } upd_path_e;

endpackage

`default_nettype wire

/* src/rmw_ctrl.sv */
`timescale 1ns/1ps
`default_nettype none

module rmw_ctrl (
  input  logic                             clk,
  input  logic                             rst,
  input  logic                             read,
  input  logic [mem_cfg_pkg::bitaddr-1:0]  rd_adr,
  input  logic                             write,
  input  logic [mem_cfg_pkg::width-1:0]    din,
  output mem_types_pkg::bank_req_t         bank_req [mem_cfg_pkg::numvbnk],
  output mem_types_pkg::dp_req_t           spare_req,
  output mem_types_pkg::map_req_t          map_req,
  input  logic [mem_cfg_pkg::width-1:0]    bank_dout [mem_cfg_pkg::numvbnk],
  input  logic [mem_cfg_pkg::width-1:0]    spare_dout,
  input  mem_types_pkg::map_entry_t        map_dout,
  output logic                             rd_vld,
  output logic [mem_cfg_pkg::width-1:0]    rd_dout
);

  typedef struct packed {
    logic [mem_cfg_pkg::bitvbnk-1:0] bank;
    logic [mem_cfg_pkg::bitvrow-1:0] row;
  } rd_stage_t;

  typedef struct packed {
    logic [mem_cfg_pkg::bitvrow-1:0] row;
    mem_types_pkg::map_entry_t       map;
    logic [mem_cfg_pkg::width-1:0]   data;
  } byp_t;

  logic [mem_cfg_pkg::bitvbnk-1:0]    rd_bank;
  logic [mem_cfg_pkg::bitvrow-1:0]    rd_row;
  logic [mem_cfg_pkg::sram_delay-1:0] rd_vld_pipe;
  rd_stage_t                          rd_pipe [mem_cfg_pkg::sram_delay];
  rd_stage_t                          rd_end;
  logic [mem_cfg_pkg::sram_delay-1:0] byp_map_we;
  logic [mem_cfg_pkg::sram_delay-1:0] byp_spare_we;
  byp_t                               byp [mem_cfg_pkg::sram_delay];
  mem_types_pkg::map_entry_t          cur_map;
  logic [mem_cfg_pkg::width-1:0]      cur_spare;
  logic                               new_hit;
  logic                               map_this;
  mem_types_pkg::upd_path_e           upd_path;

  assign rd_bank = rd_adr[mem_cfg_pkg::bitaddr-1 -: mem_cfg_pkg::bitvbnk];
  assign rd_row  = rd_adr[mem_cfg_pkg::bitvrow-1:0];
  assign rd_end  = rd_pipe[mem_cfg_pkg::sram_delay-1];

  always_ff @(posedge clk) begin
    if (rst) begin
      rd_vld_pipe  <= '0;
      byp_map_we   <= '0;
      byp_spare_we <= '0;
    end else begin
      rd_vld_pipe  <= {rd_vld_pipe[mem_cfg_pkg::sram_delay-2:0], read};
      byp_map_we   <= {byp_map_we[mem_cfg_pkg::sram_delay-2:0], map_req.write};
      byp_spare_we <= {byp_spare_we[mem_cfg_pkg::sram_delay-2:0], spare_req.write};
    end
  end

  always_ff @(posedge clk) begin
    rd_pipe[0].bank <= rd_bank;
    rd_pipe[0].row  <= rd_row;
    byp[0].row      <= rd_end.row;  // Every map and t2 write goes to the update row
    byp[0].map      <= map_req.din;
    byp[0].data     <= spare_req.din;
    for (int i = 1; i < mem_cfg_pkg::sram_delay; i++) begin
      rd_pipe[i] <= rd_pipe[i-1];
      byp[i]     <= byp[i-1];
    end
  end

  // Returned words form a snapshot from before the read cycle
  always_comb begin
    rd_vld = rd_vld_pipe[mem_cfg_pkg::sram_delay-1];
    if (map_dout.vld && (map_dout.bank == rd_end.bank)) begin
      rd_dout = spare_dout;
    end else begin
      rd_dout = bank_dout[rd_end.bank];
    end
  end

  // Bring map and t2 up to date with writes made while the read was in flight
  always_comb begin
    cur_map   = map_dout;
    cur_spare = spare_dout;
    for (int i = mem_cfg_pkg::sram_delay - 1; i >= 0; i--) begin
      if (byp_map_we[i] && (byp[i].row == rd_end.row)) begin
        cur_map = byp[i].map;
      end
      if (byp_spare_we[i] && (byp[i].row == rd_end.row)) begin
        cur_spare = byp[i].data;
      end
    end
  end

  assign new_hit  = read && (rd_bank == rd_end.bank);
  assign map_this = cur_map.vld && (cur_map.bank == rd_end.bank);

  always_comb begin
    if (!(write && rd_vld_pipe[mem_cfg_pkg::sram_delay-1])) begin
      upd_path = mem_types_pkg::upd_none;
    end else if (!new_hit) begin
      upd_path = mem_types_pkg::upd_bank;
    end else if (!cur_map.vld || map_this) begin
      upd_path = mem_types_pkg::upd_spare;
    end else begin
      upd_path = mem_types_pkg::upd_spare_evict;
    end
  end

  always_comb begin
    for (int i = 0; i < mem_cfg_pkg::numvbnk; i++) begin
      bank_req[i].read  = read && (int'(rd_bank) == i);
      bank_req[i].write = 1'b0;
      bank_req[i].row   = rd_row;
      bank_req[i].din   = din;
    end
    spare_req.read     = read;
    spare_req.rd_row   = rd_row;
    spare_req.write    = 1'b0;
    spare_req.wr_row   = rd_end.row;
    spare_req.din      = din;
    map_req.read       = read;
    map_req.rd_row     = rd_row;
    map_req.write      = 1'b0;
    map_req.wr_row     = rd_end.row;
    map_req.din.vld    = 1'b1;
    map_req.din.bank   = rd_end.bank;
    case (upd_path)
      mem_types_pkg::upd_bank: begin
        bank_req[rd_end.bank].write = 1'b1;
        bank_req[rd_end.bank].row   = rd_end.row;
        map_req.write               = map_this;  // t1 now holds the newest word
        map_req.din.vld             = 1'b0;
      end
      mem_types_pkg::upd_spare: begin
        spare_req.write = 1'b1;
        map_req.write   = 1'b1;
      end
      mem_types_pkg::upd_spare_evict: begin
        bank_req[cur_map.bank].write = 1'b1;  // Displaced word returns to its own bank
        bank_req[cur_map.bank].row   = rd_end.row;
        bank_req[cur_map.bank].din   = cur_spare;
        spare_req.write              = 1'b1;
        map_req.write                = 1'b1;
      end
      default: begin
      end
    endcase
  end

endmodule

`default_nettype wire

/* src/sram_1p.sv */
`timescale 1ns/1ps
`default_nettype none

module sram_1p #(
  parameter int width = mem_cfg_pkg::width,
  parameter int depth = mem_cfg_pkg::numvrow
) (
  input  logic                     clk,
  input  mem_types_pkg::bank_req_t req,
  output logic [width-1:0]         dout
);

  logic [width-1:0] mem [depth];
  logic [width-1:0] rd_pipe [mem_cfg_pkg::sram_delay];

  always_ff @(posedge clk) begin
    if (req.write) begin
      mem[req.row] <= req.din;
    end
  end

  always_ff @(posedge clk) begin
    if (req.read) begin
      rd_pipe[0] <= mem[req.row];  // Word enters the latency pipeline
    end
    for (int i = 1; i < mem_cfg_pkg::sram_delay; i++) begin
      rd_pipe[i] <= rd_pipe[i-1];
    end
  end

  assign dout = rd_pipe[mem_cfg_pkg::sram_delay-1];

endmodule

`default_nettype wire

/* src/sram_1r1w.sv */
`timescale 1ns/1ps
`default_nettype none

module sram_1r1w #(
  parameter int width = mem_cfg_pkg::width,
  parameter int depth = mem_cfg_pkg::numvrow
) (
  input  logic                            clk,
  input  logic                            wr_en,
  input  logic [mem_cfg_pkg::bitvrow-1:0] wr_row,
  input  logic [width-1:0]                wr_din,
  input  logic                            rd_en,
  input  logic [mem_cfg_pkg::bitvrow-1:0] rd_row,
  output logic [width-1:0]                rd_dout
);

  logic [width-1:0] mem [depth];
  logic [width-1:0] rd_pipe [mem_cfg_pkg::sram_delay];

  always_ff @(posedge clk) begin
    if (wr_en) begin
      mem[wr_row] <= wr_din;
    end
  end

  // A read of the row being written sees the old word
  always_ff @(posedge clk) begin
    if (rd_en) begin
      rd_pipe[0] <= mem[rd_row];
    end
    for (int i = 1; i < mem_cfg_pkg::sram_delay; i++) begin
      rd_pipe[i] <= rd_pipe[i-1];
    end
  end

  assign rd_dout = rd_pipe[mem_cfg_pkg::sram_delay-1];

endmodule

`default_nettype wire

/* tb.f */
src/mem_cfg_pkg.sv
src/mem_types_pkg.sv
src/sram_1p.sv
src/sram_1r1w.sv
src/rmw_ctrl.sv
src/mem_1r1u_top.sv
bench/tb_mem_1r1u.sv
